/* verilog/ahb_matrix_params.svh */
`ifndef AHB_MATRIX_PARAMS_SVH
`define AHB_MATRIX_PARAMS_SVH

// --------------------------------------------------------------------------
// device slots on the matrix
// --------------------------------------------------------------------------
`define AHB_DEVICE_COUNT      4
`define DEV_BOOT_RAM          0
`define DEV_RAM               1
`define DEV_GPIO              2
`define DEV_DEFAULT           3

// physical address map, upper address bits compared per region
`define BOOT_RAM_MATCH        7'h7f     // haddr[28:22], base 0x1fc00000
`define RAM_MATCH             3'b000    // haddr[28:26], base 0x00000000
`define GPIO_MATCH            7'h7e     // haddr[28:22], base 0x1f800000

`define BOOT_RAM_ADDR_WIDTH   10        // 1 KB
`define RAM_ADDR_WIDTH        12        // 4 KB

// board i/o
`define N_SWITCHES            16
`define N_BUTTONS             5
`define N_RED_LEDS            18
`define N_GREEN_LEDS          9

`define GPIO_SWITCHES_OFFSET  4'h0
`define GPIO_BUTTONS_OFFSET   4'h4
`define GPIO_RED_LEDS_OFFSET  4'h8
`define GPIO_GREEN_LEDS_OFFSET 4'hc

`endif

/* verilog/ahb_pkg.sv */
`include "ahb_matrix_params.svh"

package ahb_pkg;

    typedef logic [31:0] ahb_word_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } ahb_trans_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } ahb_resp_e;

    // address-phase control from the master, burst/prot/lock are not decoded
    typedef struct packed {
        ahb_word_t  haddr;
        ahb_trans_e htrans;
        logic [2:0] hsize;
        logic       hwrite;
        logic [2:0] hburst;
        logic [3:0] hprot;
        logic       hmastlock;
    } ahb_addr_phase_t;

    typedef struct packed {
        ahb_word_t  hrdata;
        logic       hreadyout;
        ahb_resp_e  hresp;
    } ahb_slave_resp_t;

    // one-hot, bit order given by the DEV_* slots
    typedef logic [`AHB_DEVICE_COUNT-1:0] dev_sel_t;

endpackage

/* verilog/ahb_ram_slave.sv */
`timescale 1ns/1ps

module ahb_ram_slave #(
    parameter int ADDR_WIDTH = 12            // byte address bits
) (
    input  logic                     HCLK,
    input  logic                     HRESETn,
    input  logic                     hsel,
    input  logic                     hready,
    input  ahb_pkg::ahb_addr_phase_t bus_req,
    input  ahb_pkg::ahb_word_t       hwdata,
    output ahb_pkg::ahb_slave_resp_t resp
);
    import ahb_pkg::*;

    localparam int WORD_AW = ADDR_WIDTH - 2;
    localparam int DEPTH   = 1 << WORD_AW;

    ahb_word_t          mem [DEPTH];

    logic               active;
    logic [3:0]         lane_en;
    logic [3:0]         lane_en_q;
    logic [WORD_AW-1:0] word_addr_q;
    logic               write_q;

    assign active = hsel & hready &
                    ((bus_req.htrans == NONSEQ) | (bus_req.htrans == SEQ));

    // byte lanes touched by this transfer, little endian
    always_comb begin
        case (bus_req.hsize)
            3'b000:  lane_en = 4'b0001 << bus_req.haddr[1:0];
            3'b001:  lane_en = bus_req.haddr[1] ? 4'b1100 : 4'b0011;
            default: lane_en = 4'b1111;      // word, wider sizes treated as word
        endcase
    end

    // --------------------------------------------------------------------------
    // address phase capture
    // --------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            write_q <= 1'b0;
        end else begin
            write_q <= active & bus_req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (active) begin
            word_addr_q <= bus_req.haddr[ADDR_WIDTH-1:2];   // upper bits alias
            lane_en_q   <= lane_en;
        end
    end

    // --------------------------------------------------------------------------
    // data phase
    // --------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (write_q) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en_q[i]) begin
                    mem[word_addr_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    assign resp = '{
        hrdata:    mem[word_addr_q],         // async read off the captured address
        hreadyout: 1'b1,
        hresp:     OKAY
    };

endmodule

/* verilog/ahb_gpio_slave.sv */
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_gpio_slave (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      hsel,
    input  logic                      hready,
    input  ahb_pkg::ahb_addr_phase_t  bus_req,
    input  ahb_pkg::ahb_word_t        hwdata,
    output ahb_pkg::ahb_slave_resp_t  resp,
    input  logic [`N_SWITCHES-1:0]    io_switches,
    input  logic [`N_BUTTONS-1:0]     io_buttons,
    output logic [`N_RED_LEDS-1:0]    io_red_leds,
    output logic [`N_GREEN_LEDS-1:0]  io_green_leds
);
    import ahb_pkg::*;

    logic       active;
    logic [3:0] offset_q;        // word-aligned register offset
    logic       write_q;
    ahb_word_t  rdata;

    assign active = hsel & hready &
                    ((bus_req.htrans == NONSEQ) | (bus_req.htrans == SEQ));

    always_ff @(posedge HCLK) begin
        if (active) begin
            offset_q <= {bus_req.haddr[3:2], 2'b00};
        end
    end

    // --------------------------------------------------------------------------
    // write path, only the leds are writable
    // --------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            write_q       <= 1'b0;
            io_red_leds   <= '0;
            io_green_leds <= '0;
        end else begin
            write_q <= active & bus_req.hwrite;
            if (write_q) begin
                case (offset_q)
                    `GPIO_RED_LEDS_OFFSET:   io_red_leds   <= hwdata[`N_RED_LEDS-1:0];
                    `GPIO_GREEN_LEDS_OFFSET: io_green_leds <= hwdata[`N_GREEN_LEDS-1:0];
                    default: ;                       // inputs ignore writes
                endcase
            end
        end
    end

    always_comb begin
        case (offset_q)
            `GPIO_SWITCHES_OFFSET:   rdata = ahb_word_t'(io_switches);
            `GPIO_BUTTONS_OFFSET:    rdata = ahb_word_t'(io_buttons);
            `GPIO_RED_LEDS_OFFSET:   rdata = ahb_word_t'(io_red_leds);
            default:                 rdata = ahb_word_t'(io_green_leds);
        endcase
    end

    assign resp = '{hrdata: rdata, hreadyout: 1'b1, hresp: OKAY};

endmodule

/* verilog/ahb_default_slave.sv */
`timescale 1ns/1ps

module ahb_default_slave (
    input  logic                     HCLK,
    input  logic                     HRESETn,
    input  logic                     hsel,
    input  logic                     hready,
    input  ahb_pkg::ahb_trans_e      htrans,
    output ahb_pkg::ahb_slave_resp_t resp
);
    import ahb_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_ERROR_FIRST           // ready low, ERROR
    } state_e;

    state_e state;
    state_e state_next;
    logic   err_second_q;        // ready high, ERROR

    always_comb begin
        state_next = ST_IDLE;
        if (state == ST_IDLE && hsel && hready && (htrans == NONSEQ || htrans == SEQ)) begin
            state_next = ST_ERROR_FIRST;
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state        <= ST_IDLE;
            err_second_q <= 1'b0;
        end else begin
            state        <= state_next;
            err_second_q <= (state == ST_ERROR_FIRST);
        end
    end

    // idle/busy transfers fall through with one ready OKAY cycle
    assign resp = '{
        hrdata:    '0,
        hreadyout: (state != ST_ERROR_FIRST),
        hresp:     (state == ST_ERROR_FIRST || err_second_q) ? ERROR : OKAY
    };

endmodule

/* verilog/ahb_slave_select.sv */
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_slave_select (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  ahb_pkg::ahb_word_t      haddr,
    input  ahb_pkg::ahb_slave_resp_t slave_resp [`AHB_DEVICE_COUNT],
    output ahb_pkg::dev_sel_t       hsel,
    output ahb_pkg::ahb_word_t      hrdata,
    output logic                    hready,
    output ahb_pkg::ahb_resp_e      hresp
);
    import ahb_pkg::*;

    localparam dev_sel_t SEL_DEFAULT = dev_sel_t'(1) << `DEV_DEFAULT;

    dev_sel_t        req_sel;    // decoded from the current address
    dev_sel_t        data_sel;   // owner of the data phase
    ahb_slave_resp_t owner_resp;

    // --------------------------------------------------------------------------
    // address decode, bits 31:29 are not looked at so segments alias
    // --------------------------------------------------------------------------
    always_comb begin
        req_sel = '0;
        if (haddr[28:22] == `BOOT_RAM_MATCH) begin
            req_sel[`DEV_BOOT_RAM] = 1'b1;
        end else if (haddr[28:22] == `GPIO_MATCH) begin
            req_sel[`DEV_GPIO] = 1'b1;
        end else if (haddr[28:26] == `RAM_MATCH) begin
            req_sel[`DEV_RAM] = 1'b1;
        end else begin
            req_sel[`DEV_DEFAULT] = 1'b1;  // nothing mapped here
        end
    end

    // a stalled data phase keeps the address phase pointed at the same slave
    assign hsel = hready ? req_sel : data_sel;

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            data_sel <= SEL_DEFAULT;
        end else if (hready) begin
            data_sel <= hsel;                // phase change
        end
    end

    // --------------------------------------------------------------------------
    // response mux
    // --------------------------------------------------------------------------
    always_comb begin
        casez (data_sel)
            4'b???1: owner_resp = slave_resp[`DEV_BOOT_RAM];
            4'b??10: owner_resp = slave_resp[`DEV_RAM];
            4'b?100: owner_resp = slave_resp[`DEV_GPIO];
            default: owner_resp = slave_resp[`DEV_DEFAULT];
        endcase
    end

    assign hrdata = owner_resp.hrdata;
    assign hready = owner_resp.hreadyout;   // only the data-phase owner can stall
    assign hresp  = owner_resp.hresp;

endmodule

/* verilog/ahb_lite_matrix.sv */
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_lite_matrix (
    input  logic                         HCLK,
    input  logic                         HRESETn,
    input  ahb_pkg::ahb_addr_phase_t     bus_req,
    input  ahb_pkg::ahb_word_t           hwdata,
    output ahb_pkg::ahb_word_t           hrdata,
    output logic                         hready,
    output ahb_pkg::ahb_resp_e           hresp,
    input  logic [`N_SWITCHES-1:0]       io_switches,
    input  logic [`N_BUTTONS-1:0]        io_buttons,
    output logic [`N_RED_LEDS-1:0]       io_red_leds,
    output logic [`N_GREEN_LEDS-1:0]     io_green_leds
);
    import ahb_pkg::*;

    dev_sel_t        hsel;                               // address-phase select
    ahb_slave_resp_t slave_resp [`AHB_DEVICE_COUNT];

    ahb_slave_select select_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .haddr      (bus_req.haddr),
        .slave_resp (slave_resp),
        .hsel       (hsel),
        .hrdata     (hrdata),
        .hready     (hready),
        .hresp      (hresp)
    );

    // --------------------------------------------------------------------------
    // slaves
    // --------------------------------------------------------------------------
    ahb_ram_slave #(.ADDR_WIDTH(`BOOT_RAM_ADDR_WIDTH)) boot_ram (
        .HCLK (HCLK), .HRESETn (HRESETn),
        .hsel (hsel[`DEV_BOOT_RAM]), .hready (hready),
        .bus_req (bus_req), .hwdata (hwdata),
        .resp (slave_resp[`DEV_BOOT_RAM])
    );

    ahb_ram_slave #(.ADDR_WIDTH(`RAM_ADDR_WIDTH)) ram (
        .HCLK (HCLK), .HRESETn (HRESETn),
        .hsel (hsel[`DEV_RAM]), .hready (hready),
        .bus_req (bus_req), .hwdata (hwdata),
        .resp (slave_resp[`DEV_RAM])
    );

    ahb_gpio_slave gpio (
        .HCLK (HCLK), .HRESETn (HRESETn),
        .hsel (hsel[`DEV_GPIO]), .hready (hready),
        .bus_req (bus_req), .hwdata (hwdata),
        .resp (slave_resp[`DEV_GPIO]),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds)
    );

    ahb_default_slave default_slave (
        .HCLK (HCLK), .HRESETn (HRESETn),
        .hsel (hsel[`DEV_DEFAULT]), .hready (hready),
        .htrans (bus_req.htrans),
        .resp (slave_resp[`DEV_DEFAULT])
    );

endmodule

/* testbench/tb_ahb_lite_matrix.sv */
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module tb_ahb_lite_matrix;
    import ahb_pkg::*;

    localparam ahb_word_t BOOT_BASE = 32'h1fc0_0000;
    localparam ahb_word_t RAM_BASE  = 32'h0000_0000;
    localparam ahb_word_t GPIO_BASE = 32'h1f80_0000;
    localparam ahb_word_t UNMAPPED  = 32'h1000_0000;    // bits 28:26 = 3'b100, no region

    localparam logic [2:0] SZ_BYTE = 3'd0;
    localparam logic [2:0] SZ_HALF = 3'd1;
    localparam logic [2:0] SZ_WORD = 3'd2;

    // transfers per test: random 32, lanes 7, back to back 8, gpio 9, error 4
    localparam int N_TRANSFERS = 32 + 7 + 8 + 9 + 4;
    localparam int CYCLE_LIMIT = 4 * N_TRANSFERS + 100;

    logic                       HCLK;
    logic                       HRESETn;
    ahb_addr_phase_t            bus_req;
    ahb_word_t                  hwdata;
    ahb_word_t                  hrdata;
    logic                       hready;
    ahb_resp_e                  hresp;
    logic [`N_SWITCHES-1:0]     io_switches;
    logic [`N_BUTTONS-1:0]      io_buttons;
    logic [`N_RED_LEDS-1:0]     io_red_leds;
    logic [`N_GREEN_LEDS-1:0]   io_green_leds;

    int        errors;
    int        cycles;
    ahb_word_t ref_mem [ahb_word_t];    // expected memory, keyed by word address

    ahb_lite_matrix dut_i (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .bus_req       (bus_req),
        .hwdata        (hwdata),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds)
    );

    initial begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_word(input string name, input ahb_word_t exp, input ahb_word_t act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input ahb_resp_e exp, input ahb_resp_e act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // bus helpers
    // ------------------------------------------------------------------------
    function automatic ahb_addr_phase_t make_req(input ahb_word_t addr, input logic write,
                                                 input logic [2:0] size);
        ahb_addr_phase_t req;
        req           = '0;
        req.haddr     = addr;
        req.htrans    = NONSEQ;
        req.hsize     = size;
        req.hwrite    = write;
        req.hprot     = 4'b0011;    // data, privileged
        return req;
    endfunction

    function automatic ahb_addr_phase_t idle_req();
        ahb_addr_phase_t req;
        req        = '0;
        req.htrans = IDLE;
        return req;
    endfunction

    // little endian lane merge, byte lane i is hwdata[8i+7:8i]
    function automatic ahb_word_t merge_lanes(input ahb_word_t old, input ahb_word_t addr,
                                              input logic [2:0] size, input ahb_word_t wdata);
        ahb_word_t merged;
        logic      hit;
        merged = old;
        for (int lane = 0; lane < 4; lane++) begin
            case (size)
                SZ_BYTE: hit = (lane == int'(addr[1:0]));
                SZ_HALF: hit = ((lane / 2) == int'(addr[1]));
                default: hit = 1'b1;
            endcase
            if (hit) begin
                merged[8*lane +: 8] = wdata[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    // runs to the rising edge that ends the current phase
    task automatic advance_phase(output ahb_word_t rdata, output ahb_resp_e resp);
        @(negedge HCLK);
        while (!hready) @(negedge HCLK);
        rdata = hrdata;
        resp  = hresp;
        @(posedge HCLK);
    endtask

    task automatic ahb_write(input ahb_word_t addr, input logic [2:0] size, input ahb_word_t data);
        ahb_word_t rd;
        ahb_resp_e rs;
        ahb_word_t key;
        key = {addr[31:2], 2'b00};
        #1 bus_req = make_req(addr, 1'b1, size);
        advance_phase(rd, rs);
        #1 bus_req = idle_req();
        hwdata = data;
        advance_phase(rd, rs);
        check_resp("hresp", OKAY, rs);
        ref_mem[key] = merge_lanes(ref_mem.exists(key) ? ref_mem[key] : '0, addr, size, data);
    endtask

    task automatic ahb_read(input ahb_word_t addr, output ahb_word_t rdata,
                            output ahb_resp_e resp);
        ahb_word_t rd;
        ahb_resp_e rs;
        #1 bus_req = make_req(addr, 1'b0, SZ_WORD);
        advance_phase(rd, rs);
        #1 bus_req = idle_req();
        advance_phase(rdata, resp);
    endtask

    task automatic expect_read(input ahb_word_t addr, input ahb_word_t exp);
        ahb_word_t rd;
        ahb_resp_e rs;
        ahb_read(addr, rd, rs);
        check_word("hrdata", exp, rd);
        check_resp("hresp", OKAY, rs);
    endtask

    task automatic read_and_compare(input ahb_word_t addr);
        expect_read(addr, ref_mem[{addr[31:2], 2'b00}]);
    endtask

    // read address phase overlaps the write data phase
    task automatic write_then_read(input ahb_word_t addr, input ahb_word_t data);
        ahb_word_t rd;
        ahb_resp_e rs;
        #1 bus_req = make_req(addr, 1'b1, SZ_WORD);
        advance_phase(rd, rs);
        #1 bus_req = make_req(addr, 1'b0, SZ_WORD);
        hwdata = data;
        advance_phase(rd, rs);
        check_resp("hresp", OKAY, rs);
        ref_mem[{addr[31:2], 2'b00}] = data;
        #1 bus_req = idle_req();
        advance_phase(rd, rs);
        check_word("hrdata", data, rd);
        check_resp("hresp", OKAY, rs);
    endtask

    task automatic check_leds(input ahb_word_t red_exp, input ahb_word_t green_exp);
        @(negedge HCLK);
        check_word("io_red_leds", red_exp, ahb_word_t'(io_red_leds));
        check_word("io_green_leds", green_exp, ahb_word_t'(io_green_leds));
        @(posedge HCLK);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state_test();
        @(negedge HCLK);
        check_bit("hready", 1'b1, hready);
        check_resp("hresp", OKAY, hresp);
        @(posedge HCLK);
        check_leds('0, '0);
    endtask

    task automatic random_rw_test();
        int unsigned off;
        ahb_word_t   boot_addr [8];
        ahb_word_t   ram_addr [8];
        for (int i = 0; i < 8; i++) begin
            off          = $urandom % 256;            // both regions hold 256 words or more
            boot_addr[i] = BOOT_BASE + (off << 2);
            ram_addr[i]  = RAM_BASE + (off << 2);     // same offset, other region
            ahb_write(boot_addr[i], SZ_WORD, $urandom);
            ahb_write(ram_addr[i], SZ_WORD, $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            read_and_compare(boot_addr[i]);
            read_and_compare(ram_addr[i]);
        end
    endtask

    // every byte of the write data differs, so a lane taken from the wrong position shows
    task automatic lane_write_test();
        ahb_word_t base;
        base = RAM_BASE + 32'h200;
        ahb_write(base, SZ_WORD, 32'h1122_3344);
        ahb_write(base + 32'd1, SZ_BYTE, 32'ha1b2_c3d4);
        read_and_compare(base);
        ahb_write(base + 32'd2, SZ_HALF, 32'hbeef_cafe);
        read_and_compare(base);
        ahb_write(base, SZ_BYTE, 32'h1234_565a);
        read_and_compare(base);
    endtask

    task automatic back_to_back_test();
        int unsigned off;
        for (int i = 0; i < 2; i++) begin
            off = $urandom % 256;
            write_then_read(BOOT_BASE + (off << 2), $urandom);
            off = $urandom % 1024;                     // 4 KB main RAM
            write_then_read(RAM_BASE + (off << 2), $urandom);
        end
    endtask

    task automatic gpio_test();
        ahb_word_t rnd;
        ahb_word_t sw_exp;
        ahb_word_t red_exp;
        ahb_word_t green_exp;
        rnd = $urandom;
        #1;
        io_switches = rnd[`N_SWITCHES-1:0];
        io_buttons  = rnd[31:32-`N_BUTTONS];
        @(posedge HCLK);
        sw_exp = ahb_word_t'(rnd[`N_SWITCHES-1:0]);
        expect_read(GPIO_BASE + `GPIO_SWITCHES_OFFSET, sw_exp);
        expect_read(GPIO_BASE + `GPIO_BUTTONS_OFFSET, ahb_word_t'(rnd[31:32-`N_BUTTONS]));

        rnd = $urandom;
        red_exp = ahb_word_t'(rnd[`N_RED_LEDS-1:0]);          // truncated to the LED count
        ahb_write(GPIO_BASE + `GPIO_RED_LEDS_OFFSET, SZ_WORD, rnd);
        check_leds(red_exp, '0);
        expect_read(GPIO_BASE + `GPIO_RED_LEDS_OFFSET, red_exp);

        rnd = $urandom;
        green_exp = ahb_word_t'(rnd[`N_GREEN_LEDS-1:0]);
        ahb_write(GPIO_BASE + `GPIO_GREEN_LEDS_OFFSET, SZ_WORD, rnd);
        check_leds(red_exp, green_exp);
        expect_read(GPIO_BASE + `GPIO_GREEN_LEDS_OFFSET, green_exp);

        // switch register is read only
        ahb_write(GPIO_BASE + `GPIO_SWITCHES_OFFSET, SZ_WORD, ~sw_exp);
        check_leds(red_exp, green_exp);
        expect_read(GPIO_BASE + `GPIO_SWITCHES_OFFSET, sw_exp);
        expect_read(GPIO_BASE + `GPIO_RED_LEDS_OFFSET, red_exp);
    endtask

    // the RAM read waits in its address phase during the stall
    task automatic unmapped_then_read(input logic write, input ahb_word_t ram_addr);
        ahb_word_t rd;
        ahb_resp_e rs;
        #1 bus_req = make_req(UNMAPPED + 32'h40, write, SZ_WORD);
        advance_phase(rd, rs);
        #1 bus_req = make_req(ram_addr, 1'b0, SZ_WORD);
        hwdata = 32'hdead_beef;
        @(negedge HCLK);
        check_bit("hready", 1'b0, hready);                  // first error cycle
        check_resp("hresp", ERROR, hresp);
        @(posedge HCLK);
        @(negedge HCLK);
        check_bit("hready", 1'b1, hready);
        check_resp("hresp", ERROR, hresp);
        @(posedge HCLK);
        #1 bus_req = idle_req();
        advance_phase(rd, rs);
        check_word("hrdata", ref_mem[{ram_addr[31:2], 2'b00}], rd);
        check_resp("hresp", OKAY, rs);
    endtask

    task automatic error_test();
        unmapped_then_read(1'b0, RAM_BASE + 32'h200);
        unmapped_then_read(1'b1, RAM_BASE + 32'h200);
    endtask

    // ------------------------------------------------------------------------
    // run control
    // ------------------------------------------------------------------------
    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge HCLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'h7286_31de));
        errors      = 0;
        HRESETn     = 1'b0;
        bus_req     = idle_req();
        hwdata      = '0;
        io_switches = '0;
        io_buttons  = '0;
        repeat (4) @(posedge HCLK);
        #1 HRESETn = 1'b1;

        reset_state_test();
        random_rw_test();
        lane_write_test();
        back_to_back_test();
        gpio_test();
        error_test();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/ahb_pkg.sv
verilog/ahb_ram_slave.sv
verilog/ahb_gpio_slave.sv
verilog/ahb_default_slave.sv
verilog/ahb_slave_select.sv
verilog/ahb_lite_matrix.sv
testbench/tb_ahb_lite_matrix.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ahb_lite_matrix
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -e '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
